// ==== source/audio_chan_if.sv ====
`default_nettype none
`timescale 1ns/1ps

// one side of the audio path
interface audio_chan_if;

	audio_types_pkg::ym_sum_t     ym_sum;     // psg sum for this side
	audio_types_pkg::dma_sample_t dma_snd;    // dma sample for this side
	logic                         sample_stb; // one cycle, new sum and sample
	audio_types_pkg::mix_sample_t mix;        // signed mix, held between strobes
	logic                         mix_stb;    // one cycle after sample_stb

	// router side, issues new samples at psg rate
	modport router (output ym_sum, output dma_snd, output sample_stb);

	// mixer takes samples and hands on the mix
	modport mixer (input ym_sum, input dma_snd, input sample_stb,
		output mix, output mix_stb);

	// dac reads mix every clk_32 cycle, no handshake
	modport dac (input mix);

endinterface

`default_nettype wire

// ==== source/audio_channel_mix.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_config.svh"

// psg plus dma mix for one side, identical for left and right
module audio_channel_mix (
	input wire          clk_32,
	input wire          xsint,    // async, active low
	audio_chan_if.mixer chan_io
);

	// low bits filled from the top of each signed value
	localparam int YM_FILL  = `AUDIO_MIX_BITS - 1 - `AUDIO_SUM_BITS;
	localparam int DMA_FILL = `AUDIO_MIX_BITS - 1 - `AUDIO_DMA_BITS;

	audio_types_pkg::ym_sum_t     ym_signed;   // psg sum around zero
	audio_types_pkg::dma_sample_t dma_signed;  // dma sample around zero
	audio_types_pkg::mix_sample_t ym_exp;
	audio_types_pkg::mix_sample_t dma_exp;
	audio_types_pkg::mix_sample_t mix_q;
	logic                         mix_stb_q;

	// offset binary to two's complement
	assign ym_signed  = chan_io.ym_sum - audio_types_pkg::ym_sum_t'(`AUDIO_YM_BIAS);
	assign dma_signed = chan_io.dma_snd - audio_types_pkg::dma_sample_t'(`AUDIO_DMA_BIAS);

	// sign bit, value, then top bits repeated so full scale reaches the rail
	assign ym_exp = {ym_signed[`AUDIO_SUM_BITS-1], ym_signed,
		ym_signed[`AUDIO_SUM_BITS-1 -: YM_FILL]};          // x16 plus fill
	assign dma_exp = {dma_signed[`AUDIO_DMA_BITS-1], dma_signed,
		dma_signed[`AUDIO_DMA_BITS-1 -: DMA_FILL]};        // x64 plus fill

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			mix_q     <= '0;     // signed zero, dac idles at half scale
			mix_stb_q <= 1'b0;
		end else begin
			if (chan_io.sample_stb)
				mix_q <= ym_exp + dma_exp;  // wraps at 15 bits
			mix_stb_q <= chan_io.sample_stb;
		end
	end

	assign chan_io.mix     = mix_q;
	assign chan_io.mix_stb = mix_stb_q;

endmodule

`default_nettype wire

// ==== source/audio_config.svh ====
`ifndef AUDIO_CONFIG_SVH
`define AUDIO_CONFIG_SVH

// ym2149 channel level and per side sum
`define AUDIO_YM_BITS 8
`define AUDIO_SUM_BITS 10

// ste dma sound sample, unsigned
`define AUDIO_DMA_BITS 8

// mixed sample fed to the sigma-delta dac
`define AUDIO_MIX_BITS 15

// left and right
`define AUDIO_NUM_CHAN 2

// clk_32 cycles per 2 mhz psg enable
`define AUDIO_CE_DIV 16

// midpoints removed before mixing
`define AUDIO_YM_BIAS 512
`define AUDIO_DMA_BIAS 128

`endif

// ==== source/audio_ctrl_pkg.sv ====
`default_nettype none

package audio_ctrl_pkg;

	// psg routing, stereo puts a on the left and c on the right
	typedef enum logic {PSG_MONO = 1'b0, PSG_STEREO = 1'b1} psg_mode_e;

	// index of a side in the per side arrays
	typedef enum logic {SIDE_LEFT = 1'b0, SIDE_RIGHT = 1'b1} chan_side_e;

endpackage

`default_nettype wire

// ==== source/audio_types_pkg.sv ====
`default_nettype none

`include "audio_config.svh"

package audio_types_pkg;

	// single psg channel level from the ym2149
	typedef logic [`AUDIO_YM_BITS-1:0] ym_level_t;

	// sum of up to three psg channels, wraps at 10 bits
	typedef logic [`AUDIO_SUM_BITS-1:0] ym_sum_t;

	// dma sound sample, offset binary around 128
	typedef logic [`AUDIO_DMA_BITS-1:0] dma_sample_t;

	// two's complement mix of psg and dma
	typedef logic signed [`AUDIO_MIX_BITS-1:0] mix_sample_t;

	// modulator accumulator, one bit per mix bit
	// carry out of it is the dac bit
	typedef logic [`AUDIO_MIX_BITS-1:0] dac_acc_t;

endpackage

`default_nettype wire

// ==== source/psg_stereo_router.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_config.svh"

module psg_stereo_router (
	input  wire                                clk_32,
	input  wire                                xsint,        // async, active low
	input  wire audio_types_pkg::ym_level_t    ym_a_i,       // psg channel a
	input  wire audio_types_pkg::ym_level_t    ym_b_i,       // psg channel b, both sides
	input  wire audio_types_pkg::ym_level_t    ym_c_i,       // psg channel c
	input  wire audio_types_pkg::dma_sample_t  dma_snd_l_i,
	input  wire audio_types_pkg::dma_sample_t  dma_snd_r_i,
	input  wire audio_ctrl_pkg::psg_mode_e     psg_stereo_i,
	audio_chan_if.router                       chan_o [`AUDIO_NUM_CHAN]
);

	localparam int CNT_BITS = $clog2(`AUDIO_CE_DIV);

	logic [CNT_BITS-1:0]          ce_cnt;   // free running psg divider
	logic                         psg_ce;   // 2 mhz enable, one cycle wide
	logic                         stb_q;    // sample strobe to both sides
	audio_types_pkg::ym_sum_t     ab_sum;
	audio_types_pkg::ym_sum_t     cb_sum;
	audio_types_pkg::ym_sum_t     abc_sum;
	audio_types_pkg::ym_sum_t     side_sum [`AUDIO_NUM_CHAN];
	audio_types_pkg::dma_sample_t side_dma [`AUDIO_NUM_CHAN];
	audio_types_pkg::ym_sum_t     sum_q    [`AUDIO_NUM_CHAN];
	audio_types_pkg::dma_sample_t dma_q    [`AUDIO_NUM_CHAN];

	// last count of the divider
	assign psg_ce = (ce_cnt == CNT_BITS'(`AUDIO_CE_DIV - 1));

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ce_cnt <= '0;
			stb_q  <= 1'b0;
		end else begin
			ce_cnt <= psg_ce ? '0 : ce_cnt + 1'b1;
			stb_q  <= psg_ce;  // sums land together with the strobe
		end
	end

	// channel sums, carries above bit 9 are dropped
	assign ab_sum  = audio_types_pkg::ym_sum_t'(ym_a_i) + audio_types_pkg::ym_sum_t'(ym_b_i);
	assign cb_sum  = audio_types_pkg::ym_sum_t'(ym_c_i) + audio_types_pkg::ym_sum_t'(ym_b_i);
	assign abc_sum = ab_sum + audio_types_pkg::ym_sum_t'(ym_c_i);

	always_comb begin
		if (psg_stereo_i == audio_ctrl_pkg::PSG_STEREO) begin
			side_sum[audio_ctrl_pkg::SIDE_LEFT]  = ab_sum;
			side_sum[audio_ctrl_pkg::SIDE_RIGHT] = cb_sum;
		end else begin
			// mono, same mix on both
			side_sum[audio_ctrl_pkg::SIDE_LEFT]  = abc_sum;
			side_sum[audio_ctrl_pkg::SIDE_RIGHT] = abc_sum;
		end
		side_dma[audio_ctrl_pkg::SIDE_LEFT]  = dma_snd_l_i;
		side_dma[audio_ctrl_pkg::SIDE_RIGHT] = dma_snd_r_i;
	end

	// inputs taken only on the psg enable
	always_ff @(posedge clk_32) begin
		if (psg_ce) begin
			sum_q <= side_sum;
			dma_q <= side_dma;
		end
	end

	for (genvar g = 0; g < `AUDIO_NUM_CHAN; g++) begin : g_side
		assign chan_o[g].ym_sum     = sum_q[g];
		assign chan_o[g].dma_snd    = dma_q[g];
		assign chan_o[g].sample_stb = stb_q;   // both sides in the same cycle
	end

endmodule

`default_nettype wire

// ==== source/sigma_delta_dac.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_config.svh"

// first order sigma-delta, one modulator per side
module sigma_delta_dac (
	input  wire       clk_32,
	input  wire       xsint,                     // async, active low
	audio_chan_if.dac chan_i [`AUDIO_NUM_CHAN],
	output wire       audio_l_o,                 // left bitstream
	output wire       audio_r_o                  // right bitstream
);

	logic dac_bit [`AUDIO_NUM_CHAN];

	for (genvar g = 0; g < `AUDIO_NUM_CHAN; g++) begin : g_mod
		audio_types_pkg::dac_acc_t offs_bin;   // mix with the sign flipped
		audio_types_pkg::dac_acc_t acc_q;
		logic [`AUDIO_MIX_BITS:0]  acc_sum;    // one extra bit for the carry
		logic                      bit_q;

		// signed zero becomes mid scale
		assign offs_bin = {~chan_i[g].mix[`AUDIO_MIX_BITS-1],
			chan_i[g].mix[`AUDIO_MIX_BITS-2:0]};

		assign acc_sum = {1'b0, acc_q} + {1'b0, offs_bin};

		// new mix taken every cycle
		// ones density over 2^15 cycles equals offs_bin
		always_ff @(posedge clk_32 or negedge xsint) begin
			if (!xsint) begin
				acc_q <= '0;
				bit_q <= 1'b0;
			end else begin
				acc_q <= acc_sum[`AUDIO_MIX_BITS-1:0];
				bit_q <= acc_sum[`AUDIO_MIX_BITS];   // carry out is the output
			end
		end

		assign dac_bit[g] = bit_q;
	end

	assign audio_l_o = dac_bit[audio_ctrl_pkg::SIDE_LEFT];
	assign audio_r_o = dac_bit[audio_ctrl_pkg::SIDE_RIGHT];

endmodule

`default_nettype wire

// ==== source/ste_audio_top.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_config.svh"

// psg and dma sound to two sigma-delta bitstreams
module ste_audio_top (
	input  wire                               clk_32,
	input  wire                               xsint,        // async, active low
	input  wire audio_types_pkg::ym_level_t   ym_a_i,
	input  wire audio_types_pkg::ym_level_t   ym_b_i,
	input  wire audio_types_pkg::ym_level_t   ym_c_i,
	input  wire audio_types_pkg::dma_sample_t dma_snd_l_i,  // ste dma left
	input  wire audio_types_pkg::dma_sample_t dma_snd_r_i,  // ste dma right
	input  wire audio_ctrl_pkg::psg_mode_e    psg_stereo_i, // mono or stereo psg
	output wire                               audio_l_o,
	output wire                               audio_r_o
);

	// one bundle per side, index by chan_side_e
	audio_chan_if chan_if [`AUDIO_NUM_CHAN] ();

	// divider, input sampling and psg routing
	psg_stereo_router u_router (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.ym_a_i       (ym_a_i),
		.ym_b_i       (ym_b_i),
		.ym_c_i       (ym_c_i),
		.dma_snd_l_i  (dma_snd_l_i),
		.dma_snd_r_i  (dma_snd_r_i),
		.psg_stereo_i (psg_stereo_i),
		.chan_o       (chan_if)
	);

	// same mixer on each side
	for (genvar g = 0; g < `AUDIO_NUM_CHAN; g++) begin : g_mix
		audio_channel_mix u_mix (
			.clk_32  (clk_32),
			.xsint   (xsint),
			.chan_io (chan_if[g])
		);
	end

	// both modulators in one block
	sigma_delta_dac u_dac (
		.clk_32    (clk_32),
		.xsint     (xsint),
		.chan_i    (chan_if),
		.audio_l_o (audio_l_o),
		.audio_r_o (audio_r_o)
	);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+source
source/audio_types_pkg.sv
source/audio_ctrl_pkg.sv
source/audio_chan_if.sv
source/psg_stereo_router.sv
source/audio_channel_mix.sv
source/sigma_delta_dac.sv
source/ste_audio_top.sv
verification/tb_clkgen.sv
verification/ste_audio_chk.sv
verification/tb_ste_audio.sv

// ==== verification/ste_audio_chk.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_config.svh"

// strobe timing of the audio path, sits inside the router
module ste_audio_chk (
	input wire                             clk_32,
	input wire                             xsint,
	input wire [$clog2(`AUDIO_CE_DIV)-1:0] ce_cnt_i,
	input wire                             sample_stb_i,
	input wire                             mix_stb_l_i,
	input wire                             mix_stb_r_i
);

	localparam int STB_GAP = `AUDIO_CE_DIV - 1;  // quiet cycles between strobes

	int unsigned fail_cnt = 0;  // summed up by the testbench

	// divider and strobes idle while in reset, first tick skipped by $past
	reset_state: assert property (@(posedge clk_32)
		(!xsint && !$past(xsint)) |->
			(ce_cnt_i == '0 && !sample_stb_i && !mix_stb_l_i && !mix_stb_r_i))
		else begin
			fail_cnt++;
			$error("divider or strobe active during reset");
		end

	// first strobe one full divider turn after release
	first_strobe: assert property (@(posedge clk_32)
		$rose(xsint) |-> !sample_stb_i [*`AUDIO_CE_DIV] ##1 sample_stb_i)
		else begin
			fail_cnt++;
			$error("first sample strobe not one divider period after reset");
		end

	strobe_spacing: assert property (@(posedge clk_32) disable iff (!xsint)
		sample_stb_i |=> !sample_stb_i [*STB_GAP] ##1 sample_stb_i)
		else begin
			fail_cnt++;
			$error("sample strobes not evenly spaced by the divider");
		end

	// mixers answer one cycle later, both sides
	mix_follows: assert property (@(posedge clk_32) disable iff (!xsint)
		sample_stb_i |=> (mix_stb_l_i && mix_stb_r_i))
		else begin
			fail_cnt++;
			$error("mix strobe missing after sample strobe");
		end

	mix_after_sample: assert property (@(posedge clk_32) disable iff (!xsint)
		(mix_stb_l_i || mix_stb_r_i) |-> $past(sample_stb_i))
		else begin
			fail_cnt++;
			$error("mix strobe without a sample strobe the cycle before");
		end

endmodule

// mix strobes live in the sibling mixers, reached through the top level interfaces
bind psg_stereo_router ste_audio_chk u_chk (
	.clk_32       (clk_32),
	.xsint        (xsint),
	.ce_cnt_i     (ce_cnt),
	.sample_stb_i (stb_q),                // drives sample_stb on both sides
	.mix_stb_l_i  (chan_if[0].mix_stb),
	.mix_stb_r_i  (chan_if[1].mix_stb)
);

`default_nettype wire

// ==== verification/tb_clkgen.sv ====
`default_nettype none
`timescale 1ns/1ps

// clk_32 and power on reset for the testbench
module tb_clkgen #(
	parameter realtime HALF_PERIOD  = 5ns,  // 10 ns clock
	parameter int      RESET_CYCLES = 3
) (
	output logic clk_32,
	output logic xsint    // active low
);

	initial begin
		clk_32 = 1'b0;
		forever #(HALF_PERIOD) clk_32 = ~clk_32;
	end

	// held low for a few edges, released on a rising edge
	initial begin
		xsint = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_32);
		xsint <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verification/tb_ste_audio.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "audio_config.svh"

module tb_ste_audio;

	localparam int NUM_WINDOWS    = 13;                     // measured tests below
	localparam int SETTLE_CYCLES  = 64;
	localparam int WIN_CYCLES     = 1 << `AUDIO_MIX_BITS;   // one accumulator turn
	localparam int IDLE_CYCLES    = 16;                     // before the first mix update
	localparam int TIMEOUT_CYCLES = NUM_WINDOWS * (WIN_CYCLES + SETTLE_CYCLES) * 5 / 4;
	localparam logic [31:0] LFSR_SEED = 32'h2406_611c;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;      // x^32 + x^22 + x^2 + x + 1

	logic                         clk_32;
	logic                         xsint;
	audio_types_pkg::ym_level_t   ym_a;
	audio_types_pkg::ym_level_t   ym_b;
	audio_types_pkg::ym_level_t   ym_c;
	audio_types_pkg::dma_sample_t dma_l;
	audio_types_pkg::dma_sample_t dma_r;
	audio_ctrl_pkg::psg_mode_e    psg_mode;
	logic                         audio_l;
	logic                         audio_r;

	logic [31:0] lfsr_state;
	int          err_cnt;
	int          check_cnt;
	int          test_cnt;
	int          cycle_cnt;

	tb_clkgen u_clk (
		.clk_32 (clk_32),
		.xsint  (xsint)
	);

	ste_audio_top uut (
		.clk_32       (clk_32),
		.xsint        (xsint),
		.ym_a_i       (ym_a),
		.ym_b_i       (ym_b),
		.ym_c_i       (ym_c),
		.dma_snd_l_i  (dma_l),
		.dma_snd_r_i  (dma_r),
		.psg_stereo_i (psg_mode),
		.audio_l_o    (audio_l),
		.audio_r_o    (audio_r)
	);

	// galois lfsr, shifts right
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ LFSR_TAPS;
		return s >> 1;
	endfunction

	// one lfsr step per bit handed out
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val        = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
		return val;
	endfunction

	// per side psg sum, wrapped to the sum width
	function automatic int psg_side_sum(input int a, input int b, input int c,
		input audio_ctrl_pkg::psg_mode_e mode, input audio_ctrl_pkg::chan_side_e side);
		int total;
		if (mode == audio_ctrl_pkg::PSG_MONO)
			total = a + b + c;
		else if (side == audio_ctrl_pkg::SIDE_LEFT)
			total = a + b;
		else
			total = c + b;
		return total % (1 << `AUDIO_SUM_BITS);
	endfunction

	// bias removed, x16 / x64 with the top bits as fill
	function automatic int mix_model(input int sum, input int dma);
		int ym_val;
		int ym_fill;
		int dma_val;
		int dma_fill;
		ym_val   = sum - `AUDIO_YM_BIAS;            // -512 .. 511
		ym_fill  = ((ym_val + 1024) % 1024) >> 6;   // top four of ten bits
		dma_val  = dma - `AUDIO_DMA_BIAS;           // -128 .. 127
		dma_fill = ((dma_val + 256) % 256) >> 2;    // top six of eight
		return ym_val * 16 + ym_fill + dma_val * 64 + dma_fill;
	endfunction

	// wrap to 15 bits and flip the sign, i.e. expected ones per window
	function automatic int offset_binary(input int mix);
		return (mix + (1 << (`AUDIO_MIX_BITS - 1))) & ((1 << `AUDIO_MIX_BITS) - 1);
	endfunction

	task automatic check_value(input string name, input string side, input int exp,
		input int act);
		check_cnt++;
		assert (act == exp) else begin
			err_cnt++;
			$display("Error %s %s: expected %0d, actual %0d", name, side, exp, act);
		end
	endtask

	// outputs low in reset, then the idle half scale pattern
	task automatic check_reset_idle();
		int acc;
		int exp_bit;
		acc = 0;
		@(negedge clk_32);
		while (!xsint) begin
			check_value("reset_hold", "left", 0, int'(audio_l));
			check_value("reset_hold", "right", 0, int'(audio_r));
			@(negedge clk_32);
		end
		for (int n = 0; n < IDLE_CYCLES; n++) begin
			@(negedge clk_32);
			acc     = acc + (1 << (`AUDIO_MIX_BITS - 1));  // signed zero mix
			exp_bit = acc >> `AUDIO_MIX_BITS;
			acc     = acc & ((1 << `AUDIO_MIX_BITS) - 1);
			check_value($sformatf("idle_start_%0d", n), "left", exp_bit, int'(audio_l));
			check_value($sformatf("idle_start_%0d", n), "right", exp_bit, int'(audio_r));
		end
	endtask

	// hold inputs, let them settle, count ones on both outputs
	task automatic run_window(input string name, input int a, input int b, input int c,
		input int dl, input int dr, input audio_ctrl_pkg::psg_mode_e mode);
		int ones_l;
		int ones_r;
		int exp_l;
		int exp_r;
		@(posedge clk_32);
		ym_a     <= audio_types_pkg::ym_level_t'(a);
		ym_b     <= audio_types_pkg::ym_level_t'(b);
		ym_c     <= audio_types_pkg::ym_level_t'(c);
		dma_l    <= audio_types_pkg::dma_sample_t'(dl);
		dma_r    <= audio_types_pkg::dma_sample_t'(dr);
		psg_mode <= mode;
		repeat (SETTLE_CYCLES) @(posedge clk_32);
		ones_l = 0;
		ones_r = 0;
		repeat (WIN_CYCLES) begin
			@(negedge clk_32);  // mid cycle, bits stable
			ones_l += int'(audio_l);
			ones_r += int'(audio_r);
		end
		exp_l = offset_binary(mix_model(psg_side_sum(a, b, c, mode,
			audio_ctrl_pkg::SIDE_LEFT), dl));
		exp_r = offset_binary(mix_model(psg_side_sum(a, b, c, mode,
			audio_ctrl_pkg::SIDE_RIGHT), dr));
		test_cnt++;
		check_value(name, "left", exp_l, ones_l);
		check_value(name, "right", exp_r, ones_r);
	endtask

	initial begin : main
		int a;
		int b;
		int c;
		int dl;
		int dr;
		lfsr_state = LFSR_SEED;
		err_cnt    = 0;
		check_cnt  = 0;
		test_cnt   = 0;
		ym_a       = '0;
		ym_b       = '0;
		ym_c       = '0;
		dma_l      = '0;
		dma_r      = '0;
		psg_mode   = audio_ctrl_pkg::PSG_MONO;

		check_reset_idle();

		// random levels, both sides from a+b+c
		for (int i = 0; i < 3; i++) begin
			a  = take_bits(8);
			b  = take_bits(8);
			c  = take_bits(8);
			dl = take_bits(8);
			dr = take_bits(8);
			run_window($sformatf("mono_rand_%0d", i), a, b, c, dl, dr,
				audio_ctrl_pkg::PSG_MONO);
		end

		// a+b left, c+b right
		for (int i = 0; i < 3; i++) begin
			a  = take_bits(8);
			b  = take_bits(8);
			c  = take_bits(8);
			dl = take_bits(8);
			dr = take_bits(8);
			run_window($sformatf("stereo_rand_%0d", i), a, b, c, dl, dr,
				audio_ctrl_pkg::PSG_STEREO);
		end

		// psg sum exactly at the bias, only dma moves the density
		for (int i = 0; i < 3; i++) begin
			a  = 128 + take_bits(7);
			c  = 255;
			b  = 512 - a - c;   // 2 .. 129
			dl = take_bits(8);
			dr = take_bits(8);
			run_window($sformatf("dma_only_%0d", i), a, b, c, dl, dr,
				audio_ctrl_pkg::PSG_MONO);
		end

		run_window("zero_mono", 0, 0, 0, 0, 0, audio_ctrl_pkg::PSG_MONO);
		run_window("zero_stereo", 0, 0, 0, 0, 0, audio_ctrl_pkg::PSG_STEREO);
		run_window("full_mono", 255, 255, 255, 255, 255, audio_ctrl_pkg::PSG_MONO);
		run_window("full_stereo", 255, 255, 255, 255, 255, audio_ctrl_pkg::PSG_STEREO);

		$display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
			test_cnt, check_cnt, err_cnt, uut.u_router.u_chk.fail_cnt);
		if (err_cnt == 0 && uut.u_router.u_chk.fail_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// run length bound, 25 percent over the measured windows
	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clk_32);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles, the tests did not finish", cycle_cnt);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
